//--- common/audioRam_macros.svh
`ifndef AUDIO_RAM_MACROS_SVH
`define AUDIO_RAM_MACROS_SVH

// ##########################################################################
// Frame geometry shared by the capture path and the sample store
// ##########################################################################

// Width of one audio sample and of one stored word
`define SAMPLE_BITS 16

// Frame address width
`define ADDR_BITS 10

// Samples per frame, one per address
`define FRAME_LEN 1024

`endif

//--- common/audioTypesPkg.sv
`include "audioRam_macros.svh"

package audioTypesPkg;

    typedef logic signed [`SAMPLE_BITS-1:0] sampleT;   // Raw or windowed sample
    typedef logic [`ADDR_BITS-1:0] addrT;              // Frame address

    // Field view of the window product
    typedef struct packed {
        logic        signExt;   // Only a copy of the sign for in-range products
        sampleT      scaled;    // Bits 30..15, the stored value
        logic [14:0] frac;      // Dropped Q0.15 fraction
    } productFieldsT;

    // Signed sample times Q0.15 coefficient
    typedef union packed {
        logic signed [2*`SAMPLE_BITS-1:0] word;
        productFieldsT                    fields;
    } productU;

endpackage

//--- common/windowPkg.sv
package windowPkg;

    // ##########################################################################
    // Window selection and coefficient format
    // ##########################################################################

    typedef enum logic {
        hammingWin = 1'b0,
        hannWin    = 1'b1
    } windowKindE;

    // Q0.15 coefficient, 0 to 32767
    typedef logic [15:0] coefT;

    // Full scale of a coefficient
    localparam int coefFullScale = 32767;

endpackage

//--- verilog/windowRom.sv
`include "audioRam_macros.svh"

module windowRom #(
    parameter windowPkg::windowKindE Kind = windowPkg::hammingWin
) (
    input  audioTypesPkg::addrT addr,
    output windowPkg::coefT     coef
);
    import windowPkg::*;

    localparam real Pi   = 3.14159265358979;
    localparam real Span = `FRAME_LEN - 1;   // Period of the cosine term

    coefT coefTable [`FRAME_LEN];

    // ##########################################################################
    // Table fill from the cosine formula
    // ##########################################################################
    initial
    begin
        real phase;
        real shape;
        for (int n = 0; n < `FRAME_LEN; n++)
        begin
            phase = $cos(2.0 * Pi * n / Span);
            if (Kind == hammingWin)
                shape = 0.54 - 0.46 * phase;
            else
                shape = 0.5 * (1.0 - phase);
            coefTable[n] = coefT'($rtoi(coefFullScale * shape + 0.5));   // Round, all positive
        end
    end

    assign coef = coefTable[addr];   // Async lookup

endmodule

//--- verilog/windowMultiplier.sv
module windowMultiplier (
    input  audioTypesPkg::sampleT     sample,
    input  windowPkg::coefT           hammingCoef,
    input  windowPkg::coefT           hannCoef,
    input  windowPkg::windowKindE     activeWindow,
    output audioTypesPkg::sampleT     windowedSample
);
    import audioTypesPkg::*;
    import windowPkg::*;

    coefT    coef;
    productU product;

    always_comb
    begin
        if (activeWindow == hannWin)
            coef = hannCoef;
        else
            coef = hammingCoef;
    end

    // Coefficient zero-extended so it multiplies as a positive value
    always_comb
    begin
        product.word = sample * $signed({1'b0, coef});
    end

    // Q0.15 product back to sample scale
    assign windowedSample = product.fields.scaled;

endmodule

//--- capture/captureController.sv
`include "audioRam_macros.svh"

module captureController (
    input  logic                  iStartLoad,
    input  logic                  reshot,
    input  logic                  startLoad,
    input  windowPkg::windowKindE windowKind,
    output audioTypesPkg::addrT   writeAddr,
    output logic                  writeEnable,
    output windowPkg::windowKindE activeWindow,
    output logic                  loadComplete
);
    import windowPkg::*;

    typedef enum logic {
        idleSt  = 1'b0,
        writeSt = 1'b1
    } stateE;

    stateE               state;
    logic [`ADDR_BITS:0] count;   // Extra bit marks the end of the frame

    // ##########################################################################
    // Capture state machine
    // ##########################################################################
    always_ff @(posedge iStartLoad or posedge reshot)
    begin
        if (reshot)
        begin
            state        <= idleSt;
            count        <= '0;
            activeWindow <= hammingWin;
            loadComplete <= 1'b0;
        end
        else
        begin
            case (state)
                idleSt:
                begin
                    if (startLoad)
                    begin
                        state        <= writeSt;
                        count        <= '0;
                        activeWindow <= windowKind;   // Held for the whole frame
                    end
                end

                writeSt:
                begin
                    if (count[`ADDR_BITS])
                    begin
                        state        <= idleSt;
                        loadComplete <= 1'b1;   // Stays up until next start
                    end
                    else
                    begin
                        count        <= count + 1'b1;
                        loadComplete <= 1'b0;
                    end
                end

                default:
                begin
                    state <= idleSt;
                end
            endcase
        end
    end

    // One write per cycle while the counter is inside the frame
    assign writeEnable = (state == writeSt) && !count[`ADDR_BITS];
    assign writeAddr   = count[`ADDR_BITS-1:0];

endmodule

//--- capture/sampleRam.sv
`include "audioRam_macros.svh"

module sampleRam (
    input  logic                  iStartLoad,
    input  logic                  writeEnable,
    input  audioTypesPkg::addrT   writeAddr,
    input  audioTypesPkg::addrT   readAddr,
    input  audioTypesPkg::sampleT writeData,
    output audioTypesPkg::sampleT readValue
);
    import audioTypesPkg::*;

    sampleT mem [`FRAME_LEN];

    // ##########################################################################
    // Single clock storage with registered read
    // ##########################################################################
    always_ff @(posedge iStartLoad)
    begin
        if (writeEnable)
            mem[writeAddr] <= writeData;
    end

    // Old data on a same-address collision
    always_ff @(posedge iStartLoad)
    begin
        readValue <= mem[readAddr];
    end

endmodule

//--- verilog/audioRam.sv
module audioRam (
    input  logic                  iStartLoad,
    input  logic                  reshot,
    input  logic                  startLoad,
    input  windowPkg::windowKindE windowKind,
    input  audioTypesPkg::sampleT sample,
    input  audioTypesPkg::addrT   readAddr,
    output audioTypesPkg::sampleT readValue,
    output logic                  loadComplete
);
    import audioTypesPkg::*;
    import windowPkg::*;

    addrT       writeAddr;
    logic       writeEnable;
    windowKindE activeWindow;
    coefT       hammingCoef;
    coefT       hannCoef;
    sampleT     windowedSample;

    // ##########################################################################
    // Capture control
    // ##########################################################################
    captureController controller (
        .iStartLoad   (iStartLoad),
        .reshot       (reshot),
        .startLoad    (startLoad),
        .windowKind   (windowKind),
        .writeAddr    (writeAddr),
        .writeEnable  (writeEnable),
        .activeWindow (activeWindow),
        .loadComplete (loadComplete)
    );

    // ##########################################################################
    // Windowing path
    // ##########################################################################
    windowRom #(
        .Kind (hammingWin)
    ) hammingRom (
        .addr (writeAddr),
        .coef (hammingCoef)
    );

    windowRom #(
        .Kind (hannWin)
    ) hannRom (
        .addr (writeAddr),
        .coef (hannCoef)
    );

    windowMultiplier multiplier (
        .sample         (sample),
        .hammingCoef    (hammingCoef),
        .hannCoef       (hannCoef),
        .activeWindow   (activeWindow),
        .windowedSample (windowedSample)
    );

    // Windowed word is what gets stored
    sampleRam ram (
        .iStartLoad  (iStartLoad),
        .writeEnable (writeEnable),
        .writeAddr   (writeAddr),
        .readAddr    (readAddr),
        .writeData   (windowedSample),
        .readValue   (readValue)
    );

endmodule

//--- dv/audioRamTb.sv
`include "audioRam_macros.svh"

module audioRamTb;
    timeunit 1ns;
    timeprecision 100ps;

    import audioTypesPkg::*;
    import windowPkg::*;

    typedef enum logic [1:0] {
        rampPat,
        fullScalePat,
        randomPat
    } patternE;

    typedef struct packed {
        windowKindE kind;
        patternE    pattern;
        logic       midStart;   // Extra start strobe inside the capture
    } testRowT;

    localparam int  numRows       = 4;
    localparam int  midStartAt    = 400;
    localparam int  timeoutCycles = numRows * (`FRAME_LEN + 1 + `FRAME_LEN + 20) + 100;
    localparam real pi            = 3.14159265358979;

    logic       iStartLoad;
    logic       reshot;
    logic       startLoad;
    windowKindE windowKind;
    sampleT     sample;
    addrT       readAddr;
    sampleT     readValue;
    logic       loadComplete;

    testRowT testTable [numRows];
    sampleT  frameIn [`FRAME_LEN];
    sampleT  frameExp [`FRAME_LEN];
    integer  seed;
    int      cycleCount;

    audioRam dut (
        .iStartLoad   (iStartLoad),
        .reshot       (reshot),
        .startLoad    (startLoad),
        .windowKind   (windowKind),
        .sample       (sample),
        .readAddr     (readAddr),
        .readValue    (readValue),
        .loadComplete (loadComplete)
    );

    always #5 iStartLoad = ~iStartLoad;   // 10 ns period

    always @(posedge iStartLoad)
    begin
        cycleCount++;
        if (cycleCount >= timeoutCycles)
        begin
            $display("Timeout after %0d cycles, a capture or readback never finished", cycleCount);
            $display("CHECKS FAILED");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    // ##########################################################################
    // Error handling and compares
    // ##########################################################################
    task automatic abortRun();
        $display("CHECKS FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic checkSample(input string name, input sampleT expected, input sampleT actual);
        if (actual !== expected)
        begin
            $display("[FAIL] time %0t %s expected %0d actual %0d", $time, name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("[FAIL] time %0t %s expected %0b actual %0b", $time, name, expected, actual);
            abortRun();
        end
    endtask

    // ##########################################################################
    // Reference model
    // ##########################################################################
    function automatic int windowCoef(input windowKindE kind, input int n);
        real c;
        real w;
        c = $cos(2.0 * pi * real'(n) / 1023.0);
        if (kind == hannWin)
            w = 0.5 * (1.0 - c);
        else
            w = 0.54 - 0.46 * c;
        return int'(32767.0 * w);   // Nearest integer
    endfunction

    task automatic buildFrame(input testRowT row);
        productU p;
        int      coef;
        for (int n = 0; n < `FRAME_LEN; n++)
        begin
            case (row.pattern)
                rampPat:      frameIn[n] = sampleT'(n * 64 - 32768);
                fullScalePat: frameIn[n] = (n % 2 == 0) ? sampleT'(-32768) : sampleT'(32767);
                default:      frameIn[n] = sampleT'($random(seed));
            endcase
            coef   = windowCoef(row.kind, n);
            p.word = int'(frameIn[n]) * coef;
            frameExp[n] = p.fields.scaled;
        end
    endtask

    // ##########################################################################
    // Capture and readback
    // ##########################################################################
    task automatic captureFrame(input testRowT row, input logic completeBefore);
        int         edgeIdx;
        windowKindE otherKind;
        otherKind  = (row.kind == hannWin) ? hammingWin : hannWin;
        startLoad  = 1'b1;
        windowKind = row.kind;
        @(posedge iStartLoad);
        #1;
        edgeIdx    = 0;
        windowKind = otherKind;   // Must not reach the running frame
        while (edgeIdx < `FRAME_LEN)
        begin
            if (edgeIdx == 0)
                checkFlag("loadComplete", completeBefore, loadComplete);
            else
                checkFlag("loadComplete", 1'b0, loadComplete);
            sample    = frameIn[edgeIdx];
            startLoad = row.midStart && (edgeIdx == midStartAt);
            @(posedge iStartLoad);
            #1;
            edgeIdx++;
        end
        sample = ~frameIn[0];   // Junk that would show any late write
        while (!loadComplete)
        begin
            @(posedge iStartLoad);
            #1;
            edgeIdx++;
        end
        if (edgeIdx != `FRAME_LEN + 1)
        begin
            $display("loadComplete rose %0d cycles after the start instead of %0d",
                     edgeIdx, `FRAME_LEN + 1);
            abortRun();
        end
    endtask

    task automatic readFrame();
        readAddr = addrT'(0);
        for (int a = 1; a <= `FRAME_LEN; a++)
        begin
            @(posedge iStartLoad);
            #1;
            checkSample($sformatf("readValue[%0d]", a - 1), frameExp[a - 1], readValue);
            checkFlag("loadComplete", 1'b1, loadComplete);   // Held until next start
            if (a < `FRAME_LEN)
                readAddr = addrT'(a);
        end
    endtask

    // ##########################################################################
    // Main sequence
    // ##########################################################################
    initial
    begin
        logic completeBefore;
        iStartLoad = 1'b0;
        reshot     = 1'b1;
        startLoad  = 1'b0;
        windowKind = hammingWin;
        sample     = '0;
        readAddr   = '0;
        seed       = 32'h278e;
        cycleCount = 0;

        testTable[0] = '{kind: hammingWin, pattern: rampPat,      midStart: 1'b0};
        testTable[1] = '{kind: hannWin,    pattern: fullScalePat, midStart: 1'b1};
        testTable[2] = '{kind: hammingWin, pattern: fullScalePat, midStart: 1'b0};
        testTable[3] = '{kind: hannWin,    pattern: randomPat,    midStart: 1'b1};

        repeat (16) @(posedge iStartLoad);
        #1;
        reshot = 1'b0;
        repeat (3)
        begin
            @(posedge iStartLoad);
            #1;
            checkFlag("loadComplete", 1'b0, loadComplete);   // No start yet
        end

        completeBefore = 1'b0;
        for (int r = 0; r < numRows; r++)
        begin
            buildFrame(testTable[r]);
            captureFrame(testTable[r], completeBefore);
            readFrame();
            completeBefore = 1'b1;
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+common
common/audioTypesPkg.sv
common/windowPkg.sv
verilog/windowRom.sv
verilog/windowMultiplier.sv
capture/captureController.sv
capture/sampleRam.sv
verilog/audioRam.sv
dv/audioRamTb.sv

//--- run.sh
#!/bin/sh
# Build the audioRam testbench with Verilator, run it, and look for the pass line

rm -rf obj_dir sim.log &&
verilator --binary --timing --timescale 1ns/100ps --top-module audioRamTb \
    -f verilog.f -o audioRamSim > build.log 2>&1 &&
./obj_dir/audioRamSim > sim.log 2>&1

grep -q "ALL CHECKS PASSED" sim.log && echo "Simulation passed" ||
{ echo "Simulation failed, see build.log and sim.log"; exit 1; }
